// File: Bender.yml
package:
  name: rv_core

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/rv_pkg.sv
      - source/fetch_stage.sv
      - source/decode_stage.sv
      - source/reg_file.sv
      - source/execute_stage.sv
      - source/mem_stage.sv
      - source/hazard_ctrl.sv
      - source/rv_core.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - dv/rv_core_checker.sv
      - dv/rv_core_tb.sv

// File: all.f
+incdir+source
source/rv_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/reg_file.sv
source/execute_stage.sv
source/mem_stage.sv
source/hazard_ctrl.sv
source/rv_core.sv
dv/rv_core_checker.sv
dv/rv_core_tb.sv

// File: dv/rv_core_checker.sv
`timescale 1ns/100ps
`include "rv_defs.svh"

module rv_core_checker (
  input logic                   clk,
  input logic                   arst_n,
  input logic                   wb_valid,
  input logic [`RV_RADDR_W-1:0] wb_rd,
  input logic                   stall,
  input logic                   flush,
  input rv_pkg::ex_mem_t        ex_mem,
  input logic                   dmem_we   // write enable inside mem_stage
);

  // --------------------------------------------------
  // reset and retirement port
  // --------------------------------------------------
  a_wb_quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !wb_valid)
    else $error("wb_valid high while reset is held");

  a_wb_rd_nonzero: assert property (@(posedge clk) disable iff (!arst_n)
    wb_valid |-> (wb_rd != '0))
    else $error("x0 write shown on the write-back port");

  // --------------------------------------------------
  // pipeline control
  // --------------------------------------------------
  a_no_stall_with_flush: assert property (@(posedge clk) disable iff (!arst_n)
    !(stall && flush))
    else $error("stall and flush both act on IF/ID");

  a_no_bubble_write: assert property (@(posedge clk) disable iff (!arst_n)
    !ex_mem.valid |-> !dmem_we)   // bubbles must leave memory alone
    else $error("data memory written by an invalid EX/MEM entry");

endmodule

// File: dv/rv_core_tb.sv
`timescale 1ns/100ps
`include "rv_defs.svh"

module rv_core_tb;

  localparam int PROG_LEN = 200;  // instructions, fetch past the end returns nops
  localparam int NSEED    = 7;    // x1..x7 seeded by addi
  localparam int NSLOTS   = 16;   // doubleword slots at byte offsets 0..120
  localparam int BODY_0   = NSEED + NSLOTS;

  // instruction kinds of the generator
  localparam int K_ADD  = 0;
  localparam int K_SUB  = 1;
  localparam int K_AND  = 2;
  localparam int K_OR   = 3;
  localparam int K_XOR  = 4;
  localparam int K_SLT  = 5;
  localparam int K_ADDI = 6;
  localparam int K_LD   = 7;
  localparam int K_SD   = 8;
  localparam int K_BEQ  = 9;

  logic                   clk;
  logic                   arst_n;
  logic [`RV_XLEN-1:0]    imem_addr;
  logic [`RV_ILEN-1:0]    imem_data;
  logic                   wb_valid;
  logic [`RV_RADDR_W-1:0] wb_rd;
  logic [`RV_XLEN-1:0]    wb_data;

  logic [`RV_ILEN-1:0]    prog  [0:PROG_LEN-1];  // encoded words
  int                     kind  [0:PROG_LEN-1];  // fields as generated
  int                     f_rd  [0:PROG_LEN-1];
  int                     f_rs1 [0:PROG_LEN-1];
  int                     f_rs2 [0:PROG_LEN-1];
  int                     f_imm [0:PROG_LEN-1];
  logic [`RV_RADDR_W-1:0] exp_rd  [$];           // expected retirements in order
  logic [`RV_XLEN-1:0]    exp_val [$];
  int                     n_exp;
  int                     n_seen;
  int                     error_count;
  integer                 seed;

  rv_core i_rv_core (
    .clk, .arst_n, .imem_addr, .imem_data, .wb_valid, .wb_rd, .wb_data
  );

  bind rv_core rv_core_checker i_checker (
    .clk(clk), .arst_n(arst_n), .wb_valid(wb_valid), .wb_rd(wb_rd), .stall(stall),
    .flush(flush), .ex_mem(ex_mem), .dmem_we(i_mem.dmem_we)
  );

  // instruction port answers in the same cycle
  assign imem_data = ((imem_addr >> 2) < PROG_LEN) ? prog[imem_addr[9:2]] : `RV_NOP;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // --------------------------------------------------
  // program encoding, RV64I base formats
  // --------------------------------------------------
  function automatic logic [31:0] encode(input int k, input int rd, input int rs1,
                                         input int rs2, input int imm);
    logic [4:0]  d;
    logic [4:0]  s1;
    logic [4:0]  s2;
    logic [12:0] im;
    d  = rd[4:0];
    s1 = rs1[4:0];
    s2 = rs2[4:0];
    im = imm[12:0];
    case (k)
      K_ADD:   return {7'b0000000, s2, s1, 3'b000, d, 7'b0110011};
      K_SUB:   return {7'b0100000, s2, s1, 3'b000, d, 7'b0110011};
      K_AND:   return {7'b0000000, s2, s1, 3'b111, d, 7'b0110011};
      K_OR:    return {7'b0000000, s2, s1, 3'b110, d, 7'b0110011};
      K_XOR:   return {7'b0000000, s2, s1, 3'b100, d, 7'b0110011};
      K_SLT:   return {7'b0000000, s2, s1, 3'b010, d, 7'b0110011};
      K_ADDI:  return {im[11:0], s1, 3'b000, d, 7'b0010011};
      K_LD:    return {im[11:0], s1, 3'b011, d, 7'b0000011};
      K_SD:    return {im[11:5], s2, s1, 3'b011, im[4:0], 7'b0100011};
      default: return {im[12], im[10:5], s2, s1, 3'b000, im[4:1], im[11], 7'b1100011};
    endcase
  endfunction

  function automatic void put(input int i, input int k, input int rd, input int rs1,
                              input int rs2, input int imm);
    kind[i]  = k;
    f_rd[i]  = rd;
    f_rs1[i] = rs1;
    f_rs2[i] = rs2;
    f_imm[i] = imm;
    prog[i]  = encode(k, rd, rs1, rs2, imm);
  endfunction

  // seeds, then every slot stored once so no load reads an empty word
  task automatic gen_program();
    int i;
    int sel;
    int rd;
    int rs1;
    int rs2;
    int slot;
    int k;
    for (i = 0; i < NSEED; i++) begin
      put(i, K_ADDI, i + 1, 0, 0, $random(seed) % 2048);
    end
    for (i = 0; i < NSLOTS; i++) begin
      put(NSEED + i, K_SD, 0, 0, 1 + (i % NSEED), 8 * i);
    end
    i = BODY_0;
    while (i < PROG_LEN) begin
      sel  = {$random(seed)} % 10;
      rd   = {$random(seed)} % 8;    // few registers, so neighbours depend often
      rs1  = {$random(seed)} % 8;
      rs2  = {$random(seed)} % 8;
      slot = {$random(seed)} % NSLOTS;
      if (sel < 4) begin
        put(i, {$random(seed)} % 6, rd, rs1, rs2, 0);
      end else if (sel < 6) begin
        put(i, K_ADDI, rd, rs1, 0, $random(seed) % 2048);
      end else if (sel == 6) begin
        put(i, K_LD, rd, 0, 0, 8 * slot);
      end else if (sel == 7) begin
        put(i, K_SD, 0, 0, rs2, 8 * slot);
        if (i + 3 < PROG_LEN) begin  // store, reload, use at once
          put(i + 1, K_LD, 1 + rd % 7, 0, 0, 8 * slot);
          put(i + 2, K_ADD, rs1, 1 + rd % 7, 1 + rd % 7, 0);
          i += 2;
        end
      end else begin
        k = 3 + {$random(seed)} % 4;  // skips past both flushed slots
        if (i + k < PROG_LEN) begin
          put(i, K_BEQ, 0, rs1, (sel == 8) ? rs1 : rs2, 4 * k);
        end else begin
          put(i, K_ADDI, rd, rs1, 0, 1);
        end
      end
      i++;
    end
  endtask

  // --------------------------------------------------
  // instruction level model
  // --------------------------------------------------
  function automatic void run_reference();
    logic [`RV_XLEN-1:0] x   [0:31];
    logic [`RV_XLEN-1:0] mem [0:NSLOTS-1];
    logic [`RV_XLEN-1:0] a;
    logic [`RV_XLEN-1:0] b;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] res;
    int                  pc;
    for (int j = 0; j < 32; j++) begin
      x[j] = '0;
    end
    for (int j = 0; j < NSLOTS; j++) begin
      mem[j] = '0;
    end
    pc = 0;
    while (pc < PROG_LEN) begin
      a   = x[f_rs1[pc]];
      b   = x[f_rs2[pc]];
      imm = longint'(f_imm[pc]);
      res = '0;
      case (kind[pc])
        K_ADD:  res = a + b;
        K_SUB:  res = a - b;
        K_AND:  res = a & b;
        K_OR:   res = a | b;
        K_XOR:  res = a ^ b;
        K_SLT:  res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
        K_ADDI: res = a + imm;
        K_LD:   res = mem[f_imm[pc] / 8];   // base is always x0
        K_SD:   mem[f_imm[pc] / 8] = b;
        default: ;
      endcase
      if (kind[pc] != K_SD && kind[pc] != K_BEQ && f_rd[pc] != 0) begin
        x[f_rd[pc]] = res;                  // x0 writes vanish
        exp_rd.push_back(f_rd[pc]);
        exp_val.push_back(res);
      end
      if (kind[pc] == K_BEQ && a == b) begin
        pc += f_imm[pc] / 4;
      end else begin
        pc++;
      end
    end
  endfunction

  task automatic check_value(input string name, input logic [`RV_XLEN-1:0] got,
                             input logic [`RV_XLEN-1:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("Verification failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // compare each retirement, sampled away from the active edge
  always @(negedge clk) begin
    if (!arst_n) begin
      check_value("wb_valid", wb_valid, 1'b0);
      check_value("imem_addr", imem_addr, `RV_RESET_PC);  // fetch waits at the reset vector
    end else if (wb_valid) begin
      if (n_seen >= n_exp) begin
        check_value("wb_valid", wb_valid, 1'b0);   // nothing more may retire
      end else begin
        check_value("wb_rd", wb_rd, exp_rd[n_seen]);
        check_value("wb_data", wb_data, exp_val[n_seen]);
        n_seen++;
      end
    end
  end

  initial begin
    arst_n      = 1'b0;
    n_seen      = 0;
    error_count = 0;
    seed        = 32'h3fd3_515f;
    gen_program();
    run_reference();
    n_exp = exp_rd.size();
    repeat (4) @(negedge clk);
    arst_n = 1'b1;
    wait (n_seen == n_exp);
    repeat (10) @(negedge clk);  // stray late writes still get caught
    if (error_count == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      $display("Verification failed");
      $fatal(1, "mismatches seen");
    end
  end

  // watchdog, ten cycles per instruction is far above the worst case
  initial begin
    repeat (10 * PROG_LEN + 4) @(posedge clk);
    $display("Timeout: only %0d of %0d expected write-backs arrived", n_seen, n_exp);
    $display("Verification failed");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: source/decode_stage.sv
`timescale 1ns/100ps
`include "rv_defs.svh"

module decode_stage (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   stall,
  input  logic                   flush,
  input  logic                   if_valid,
  input  logic [`RV_ILEN-1:0]    if_instr,
  input  logic [`RV_XLEN-1:0]    if_pc,
  input  logic [`RV_XLEN-1:0]    rs1_data,
  input  logic [`RV_XLEN-1:0]    rs2_data,
  output logic [`RV_RADDR_W-1:0] rs1_addr,
  output logic [`RV_RADDR_W-1:0] rs2_addr,
  output rv_pkg::id_ex_t         id_ex
);

  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic                supported;   // opcode and funct fields are in the subset
  rv_pkg::id_ex_t      id_next;

  assign funct3 = if_instr[14:12];
  assign funct7 = if_instr[31:25];

  // sign-extended immediates
  assign imm_i = {{52{if_instr[31]}}, if_instr[31:20]};
  assign imm_s = {{52{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
  assign imm_b = {{51{if_instr[31]}}, if_instr[31], if_instr[7], if_instr[30:25],
                  if_instr[11:8], 1'b0};

  // --------------------------------------------------
  // field split by major opcode
  // --------------------------------------------------
  always_comb begin
    id_next   = '0;
    supported = 1'b1;
    rs1_addr  = '0;          // unused sources stay at x0 so they never stall
    rs2_addr  = '0;
    case (rv_pkg::opcode_e'(if_instr[6:0]))
      rv_pkg::OP: begin
        rs1_addr       = if_instr[19:15];
        rs2_addr       = if_instr[24:20];
        id_next.rd     = if_instr[11:7];
        id_next.reg_we = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: id_next.alu_op = rv_pkg::ADD;
          10'b0100000_000: id_next.alu_op = rv_pkg::SUB;
          10'b0000000_111: id_next.alu_op = rv_pkg::AND;
          10'b0000000_110: id_next.alu_op = rv_pkg::OR;
          10'b0000000_100: id_next.alu_op = rv_pkg::XOR;
          10'b0000000_010: id_next.alu_op = rv_pkg::SLT;
          default:         supported      = 1'b0;
        endcase
      end
      rv_pkg::OP_IMM: begin  // addi
        rs1_addr        = if_instr[19:15];
        id_next.rd      = if_instr[11:7];
        id_next.reg_we  = 1'b1;
        id_next.use_imm = 1'b1;
        id_next.imm     = imm_i;
        supported       = (funct3 == 3'b000);
      end
      rv_pkg::LOAD: begin    // ld, address is rs1 + imm
        rs1_addr        = if_instr[19:15];
        id_next.rd      = if_instr[11:7];
        id_next.reg_we  = 1'b1;
        id_next.mem_re  = 1'b1;
        id_next.use_imm = 1'b1;
        id_next.imm     = imm_i;
        supported       = (funct3 == 3'b011);
      end
      rv_pkg::STORE: begin   // sd, rs2 is the store data
        rs1_addr        = if_instr[19:15];
        rs2_addr        = if_instr[24:20];
        id_next.mem_we  = 1'b1;
        id_next.use_imm = 1'b1;
        id_next.imm     = imm_s;
        supported       = (funct3 == 3'b011);
      end
      rv_pkg::BRANCH: begin  // beq, compared in execute
        rs1_addr          = if_instr[19:15];
        rs2_addr          = if_instr[24:20];
        id_next.is_branch = 1'b1;
        id_next.imm       = imm_b;
        supported         = (funct3 == 3'b000);
      end
      default: supported = 1'b0;
    endcase
    id_next.valid    = 1'b1;
    id_next.pc       = if_pc;
    id_next.rs1      = rs1_addr;
    id_next.rs2      = rs2_addr;
    id_next.rs1_data = rs1_data;
    id_next.rs2_data = rs2_data;
    if (!(if_valid && supported)) begin
      id_next = '0;          // anything outside the subset retires as a bubble
    end
  end

  // ID/EX register
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      id_ex <= '0;
    end else if (stall || flush) begin
      id_ex <= '0;           // bubble
    end else begin
      id_ex <= id_next;
    end
  end

endmodule

// File: source/execute_stage.sv
`timescale 1ns/100ps
`include "rv_defs.svh"

module execute_stage (
  input  logic                clk,
  input  logic                arst_n,
  input  rv_pkg::id_ex_t      id_ex,
  input  rv_pkg::fwd_sel_e    fwd_a,
  input  rv_pkg::fwd_sel_e    fwd_b,
  input  rv_pkg::mem_wb_t     mem_wb,
  output rv_pkg::ex_mem_t     ex_mem,
  output logic                br_taken,
  output logic [`RV_XLEN-1:0] br_target
);

  logic [`RV_XLEN-1:0] op_a;     // forwarded rs1
  logic [`RV_XLEN-1:0] rs2_fwd;  // forwarded rs2, also the store data
  logic [`RV_XLEN-1:0] op_b;
  logic [`RV_XLEN-1:0] alu_res;

  // --------------------------------------------------
  // operand forwarding
  // --------------------------------------------------
  function automatic logic [`RV_XLEN-1:0] fwd_mux(
    input rv_pkg::fwd_sel_e    sel,
    input logic [`RV_XLEN-1:0] reg_val,
    input logic [`RV_XLEN-1:0] ex_val,
    input logic [`RV_XLEN-1:0] wb_val
  );
    case (sel)
      rv_pkg::EX_MEM: return ex_val;
      rv_pkg::MEM_WB: return wb_val;
      default:        return reg_val;
    endcase
  endfunction

  assign op_a    = fwd_mux(fwd_a, id_ex.rs1_data, ex_mem.alu, mem_wb.result);
  assign rs2_fwd = fwd_mux(fwd_b, id_ex.rs2_data, ex_mem.alu, mem_wb.result);
  assign op_b    = id_ex.use_imm ? id_ex.imm : rs2_fwd;

  // alu
  always_comb begin
    case (id_ex.alu_op)
      rv_pkg::ADD: alu_res = op_a + op_b;
      rv_pkg::SUB: alu_res = op_a - op_b;
      rv_pkg::AND: alu_res = op_a & op_b;
      rv_pkg::OR:  alu_res = op_a | op_b;
      rv_pkg::XOR: alu_res = op_a ^ op_b;
      rv_pkg::SLT: alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      default:     alu_res = op_a + op_b;
    endcase
  end

  // beq resolves here, target is pc relative
  assign br_taken  = id_ex.valid && id_ex.is_branch && (op_a == rs2_fwd);
  assign br_target = id_ex.pc + id_ex.imm;

  // --------------------------------------------------
  // EX/MEM register
  // --------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_mem <= '0;
    end else begin
      ex_mem.valid      <= id_ex.valid;
      ex_mem.rd         <= id_ex.rd;
      ex_mem.reg_we     <= id_ex.reg_we;
      ex_mem.mem_re     <= id_ex.mem_re;
      ex_mem.mem_we     <= id_ex.mem_we;
      ex_mem.alu        <= alu_res;
      ex_mem.store_data <= rs2_fwd;
    end
  end

endmodule

// File: source/fetch_stage.sv
`timescale 1ns/100ps
`include "rv_defs.svh"

module fetch_stage (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                stall,
  input  logic                flush,
  input  logic                br_taken,
  input  logic [`RV_XLEN-1:0] br_target,
  input  logic [`RV_ILEN-1:0] imem_data,
  output logic [`RV_XLEN-1:0] imem_addr,
  output logic [`RV_XLEN-1:0] if_pc,
  output logic [`RV_ILEN-1:0] if_instr,
  output logic                if_valid
);

  logic [`RV_XLEN-1:0] pc;
  logic [`RV_XLEN-1:0] pc_next;

  // next pc, a taken branch beats the load-use hold
  always_comb begin
    if (br_taken) begin
      pc_next = br_target;     // redirect from execute
    end else if (stall) begin
      pc_next = pc;            // refetch same word
    end else begin
      pc_next = pc + 'd4;      // sequential
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= `RV_RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  assign imem_addr = pc;  // external port answers in the same cycle

  // --------------------------------------------------
  // IF/ID register
  // --------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      if_valid <= 1'b0;
      if_instr <= `RV_NOP;
      if_pc    <= `RV_RESET_PC;
    end else if (flush) begin
      if_valid <= 1'b0;        // younger instruction killed
      if_instr <= `RV_NOP;
    end else if (!stall) begin
      if_valid <= 1'b1;
      if_instr <= imem_data;
      if_pc    <= pc;
    end
  end

endmodule

// File: source/hazard_ctrl.sv
`timescale 1ns/100ps
`include "rv_defs.svh"

module hazard_ctrl (
  input  rv_pkg::id_ex_t         id_ex,
  input  rv_pkg::ex_mem_t        ex_mem,
  input  rv_pkg::mem_wb_t        mem_wb,
  input  logic [`RV_RADDR_W-1:0] rs1_addr,   // sources of the decoding instruction
  input  logic [`RV_RADDR_W-1:0] rs2_addr,
  input  logic                   br_taken,
  output logic                   stall,
  output logic                   flush,
  output rv_pkg::fwd_sel_e       fwd_a,
  output rv_pkg::fwd_sel_e       fwd_b
);

  logic ex_wr;     // EX/MEM will write a nonzero rd
  logic wb_wr;     // same for MEM/WB
  logic load_use;

  assign ex_wr = ex_mem.valid && ex_mem.reg_we && (ex_mem.rd != '0);
  assign wb_wr = mem_wb.valid && mem_wb.reg_we && (mem_wb.rd != '0);

  // --------------------------------------------------
  // forwarding, nearest older writer wins
  // --------------------------------------------------
  function automatic rv_pkg::fwd_sel_e pick_src(
    input logic [`RV_RADDR_W-1:0] src,
    input logic                   ex_hit_ok,
    input logic [`RV_RADDR_W-1:0] ex_rd,
    input logic                   wb_hit_ok,
    input logic [`RV_RADDR_W-1:0] wb_rd
  );
    if (ex_hit_ok && (ex_rd == src)) begin
      return rv_pkg::EX_MEM;
    end else if (wb_hit_ok && (wb_rd == src)) begin
      return rv_pkg::MEM_WB;
    end else begin
      return rv_pkg::REG;
    end
  endfunction

  // evaluated on the operands now in execute
  assign fwd_a = pick_src(id_ex.rs1, ex_wr, ex_mem.rd, wb_wr, mem_wb.rd);
  assign fwd_b = pick_src(id_ex.rs2, ex_wr, ex_mem.rd, wb_wr, mem_wb.rd);

  // --------------------------------------------------
  // load-use stall and branch flush
  // --------------------------------------------------
  assign load_use = id_ex.valid && id_ex.mem_re && (id_ex.rd != '0) &&
                    ((id_ex.rd == rs1_addr) || (id_ex.rd == rs2_addr));

  assign flush = br_taken;
  assign stall = load_use;  // a load and a beq never share execute

endmodule

// File: source/mem_stage.sv
`timescale 1ns/100ps
`include "rv_defs.svh"

module mem_stage (
  input  logic            clk,
  input  logic            arst_n,
  input  rv_pkg::ex_mem_t ex_mem,
  output rv_pkg::mem_wb_t mem_wb
);

  localparam int DMEM_DEPTH = 1 << `RV_DMEM_AW;

  logic [`RV_XLEN-1:0]    dmem [0:DMEM_DEPTH-1];  // doubleword storage
  logic [`RV_DMEM_AW-1:0] dmem_idx;
  logic                   dmem_we;
  logic [`RV_XLEN-1:0]    ld_data;

  // byte address to doubleword index, low three bits dropped
  assign dmem_idx = ex_mem.alu[`RV_DMEM_AW+2:3];
  assign dmem_we  = ex_mem.mem_we;  // bubbles arrive with mem_we low

  // --------------------------------------------------
  // data memory
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (dmem_we) begin
      dmem[dmem_idx] <= ex_mem.store_data;
    end
  end

  assign ld_data = dmem[dmem_idx];  // async read

  // MEM/WB register, load data or alu result
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mem_wb <= '0;
    end else begin
      mem_wb.valid  <= ex_mem.valid;
      mem_wb.rd     <= ex_mem.rd;
      mem_wb.reg_we <= ex_mem.reg_we;
      mem_wb.result <= ex_mem.mem_re ? ld_data : ex_mem.alu;
    end
  end

endmodule

// File: source/reg_file.sv
`timescale 1ns/100ps
`include "rv_defs.svh"

module reg_file (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic [`RV_RADDR_W-1:0] rs1_addr,
  input  logic [`RV_RADDR_W-1:0] rs2_addr,
  output logic [`RV_XLEN-1:0]    rs1_data,
  output logic [`RV_XLEN-1:0]    rs2_data,
  input  rv_pkg::mem_wb_t        mem_wb
);

  logic [`RV_XLEN-1:0] regs [1:`RV_NREGS-1];  // x0 has no storage
  logic                wr_en;

  assign wr_en = mem_wb.valid && mem_wb.reg_we && (mem_wb.rd != '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[mem_wb.rd] <= mem_wb.result;
    end
  end

  // one read port, with the write of this cycle passed through
  function automatic logic [`RV_XLEN-1:0] read_port(input logic [`RV_RADDR_W-1:0] addr);
    if (addr == '0) begin
      return '0;
    end else if (wr_en && (mem_wb.rd == addr)) begin
      return mem_wb.result;
    end else begin
      return regs[addr];
    end
  endfunction

  always_comb rs1_data = read_port(rs1_addr);
  always_comb rs2_data = read_port(rs2_addr);

endmodule

// File: source/rv_core.sv
`timescale 1ns/100ps
`include "rv_defs.svh"

module rv_core (
  input  logic                   clk,
  input  logic                   arst_n,
  output logic [`RV_XLEN-1:0]    imem_addr,
  input  logic [`RV_ILEN-1:0]    imem_data,
  output logic                   wb_valid,   // one pulse per retiring write
  output logic [`RV_RADDR_W-1:0] wb_rd,
  output logic [`RV_XLEN-1:0]    wb_data
);

  // --------------------------------------------------
  // stage to stage wires
  // --------------------------------------------------
  logic [`RV_XLEN-1:0]    if_pc;
  logic [`RV_ILEN-1:0]    if_instr;
  logic                   if_valid;
  logic [`RV_RADDR_W-1:0] rs1_addr;
  logic [`RV_RADDR_W-1:0] rs2_addr;
  logic [`RV_XLEN-1:0]    rs1_data;
  logic [`RV_XLEN-1:0]    rs2_data;
  rv_pkg::id_ex_t         id_ex;
  rv_pkg::ex_mem_t        ex_mem;
  rv_pkg::mem_wb_t        mem_wb;
  logic                   br_taken;
  logic [`RV_XLEN-1:0]    br_target;
  logic                   stall;
  logic                   flush;
  rv_pkg::fwd_sel_e       fwd_a;
  rv_pkg::fwd_sel_e       fwd_b;

  fetch_stage i_fetch (
    .clk, .arst_n, .stall, .flush, .br_taken, .br_target,
    .imem_data, .imem_addr, .if_pc, .if_instr, .if_valid
  );

  decode_stage i_decode (
    .clk, .arst_n, .stall, .flush, .if_valid, .if_instr, .if_pc,
    .rs1_data, .rs2_data, .rs1_addr, .rs2_addr, .id_ex
  );

  reg_file i_reg_file (
    .clk, .arst_n, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data, .mem_wb
  );

  execute_stage i_execute (
    .clk, .arst_n, .id_ex, .fwd_a, .fwd_b, .mem_wb, .ex_mem, .br_taken, .br_target
  );

  mem_stage i_mem (
    .clk, .arst_n, .ex_mem, .mem_wb
  );

  hazard_ctrl i_hazard (
    .id_ex, .ex_mem, .mem_wb, .rs1_addr, .rs2_addr, .br_taken,
    .stall, .flush, .fwd_a, .fwd_b
  );

  // retirement port, x0 writes are hidden
  assign wb_valid = mem_wb.valid && mem_wb.reg_we && (mem_wb.rd != '0);
  assign wb_rd    = mem_wb.rd;
  assign wb_data  = mem_wb.result;

endmodule

// File: source/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// --------------------------------------------------
// architectural sizes
// --------------------------------------------------
`define RV_XLEN     64   // integer register and data width
`define RV_ILEN     32   // instruction word width
`define RV_NREGS    32   // x0 to x31
`define RV_RADDR_W  5    // register index bits

// data memory depth in doublewords, 256 entries
`define RV_DMEM_AW  8

// --------------------------------------------------
// fixed encodings
// --------------------------------------------------
`define RV_RESET_PC 64'h0000_0000_0000_0000  // first fetch address
`define RV_NOP      32'h0000_0013            // addi x0, x0, 0

`endif

// File: source/rv_pkg.sv
`include "rv_defs.svh"

package rv_pkg;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP     = 7'b0110011,  // add sub and or xor slt
    OP_IMM = 7'b0010011,  // addi only
    LOAD   = 7'b0000011,  // ld only
    STORE  = 7'b0100011,  // sd only
    BRANCH = 7'b1100011   // beq only
  } opcode_e;

  // alu operations
  typedef enum logic [2:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLT   // signed set-less-than
  } alu_op_e;

  // where an execute operand comes from
  typedef enum logic [1:0] {
    REG,     // value read in decode
    EX_MEM,  // alu result one stage ahead
    MEM_WB   // write-back value two stages ahead
  } fwd_sel_e;

  // --------------------------------------------------
  // stage registers
  // --------------------------------------------------
  typedef struct packed {
    logic                   valid;
    logic [`RV_XLEN-1:0]    pc;
    logic [`RV_RADDR_W-1:0] rs1;       // source addresses, zero when unused
    logic [`RV_RADDR_W-1:0] rs2;
    logic [`RV_XLEN-1:0]    rs1_data;
    logic [`RV_XLEN-1:0]    rs2_data;
    logic [`RV_XLEN-1:0]    imm;       // already sign extended
    logic [`RV_RADDR_W-1:0] rd;
    alu_op_e                alu_op;
    logic                   use_imm;   // operand b from imm
    logic                   reg_we;
    logic                   mem_re;
    logic                   mem_we;
    logic                   is_branch;
  } id_ex_t;

  typedef struct packed {
    logic                   valid;
    logic [`RV_RADDR_W-1:0] rd;
    logic                   reg_we;
    logic                   mem_re;
    logic                   mem_we;
    logic [`RV_XLEN-1:0]    alu;         // result or memory address
    logic [`RV_XLEN-1:0]    store_data;
  } ex_mem_t;

  typedef struct packed {
    logic                   valid;
    logic [`RV_RADDR_W-1:0] rd;
    logic                   reg_we;
    logic [`RV_XLEN-1:0]    result;
  } mem_wb_t;

endpackage
